// File: Bender.yml
package:
  name: opl3_channel_mix

sources:
  - files:
      - hdl/opl3_mix_pkg.sv
      - hdl/channel_sequencer.sv
      - hdl/connection_mixer.sv
      - hdl/output_accumulator.sv
      - hdl/opl3_channel_mix.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/opl3_channel_mix_asserts.sv
      - sim/tb_opl3_channel_mix.sv

// File: compile.f
+incdir+include
hdl/opl3_mix_pkg.sv
hdl/channel_sequencer.sv
hdl/connection_mixer.sv
hdl/output_accumulator.sv
hdl/opl3_channel_mix.sv
sim/opl3_channel_mix_asserts.sv
sim/tb_opl3_channel_mix.sv

// File: hdl/channel_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Walks the channels of one sample frame, one per cycle.
// A strobe seen while a frame runs is dropped.
// Mode is sampled with the strobe; OPL3 needs num_banks of 2.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module channel_sequencer #(
    parameter int num_banks = 2
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     sample_clk_en,
    input  logic                     is_new,
    output opl3_mix_pkg::chan_item_t item
);

    localparam logic [3:0] last_chan = 4'(opl3_mix_pkg::chans_per_bank - 1);

    logic       running;
    logic       opl3_frame;   // this frame covers both banks
    logic       bank;
    logic [3:0] chan;
    logic       final_chan;

    // last channel of bank 1, or of bank 0 in OPL2 mode
    assign final_chan = (chan == last_chan) && (bank || !opl3_frame);

    always_ff @(posedge clk) begin
        if (reset) begin
            running    <= 1'b0;
            opl3_frame <= 1'b0;
            bank       <= 1'b0;
            chan       <= '0;
        end else if (!running) begin
            if (sample_clk_en) begin
                running    <= 1'b1;
                opl3_frame <= is_new && (num_banks > 1);
                bank       <= 1'b0;
                chan       <= '0;
            end
        end else if (final_chan) begin
            running <= 1'b0;             // back to idle until the next strobe
        end else if (chan == last_chan) begin
            bank <= 1'b1;                // move on to bank 1
            chan <= '0;
        end else begin
            chan <= chan + 4'd1;
        end
    end

    // output register, one edge behind the counter
    always_ff @(posedge clk) begin
        if (reset) begin
            item <= '0;
        end else begin
            item.valid <= running;
            item.last  <= running && final_chan;
            item.bank  <= bank;
            item.chan  <= chan;
        end
    end

endmodule

// File: hdl/connection_mixer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Applies the 2- and 4-operator connections to one channel.
// Channels 0-2 with four_op_sel set use the 4-op algorithm;
// their partners 3-5 then give zero. Result is registered.
// ops and cfg must be stable for the whole frame.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module connection_mixer #(
    parameter int num_banks = 2
) (
    input  logic                     clk,
    input  logic                     reset,
    input  opl3_mix_pkg::chan_item_t in_item,
    input  opl3_mix_pkg::bank_ops_t  ops [num_banks],
    input  opl3_mix_pkg::bank_cfg_t  cfg [num_banks],
    output opl3_mix_pkg::mix_item_t  out_item
);

    opl3_mix_pkg::bank_ops_t   bank_ops;
    opl3_mix_pkg::bank_cfg_t   bank_cfg;
    opl3_mix_pkg::chan_cfg_t   chan_cfg;
    logic                      bank_sel;
    logic [1:0]                grp;        // channel / 3
    logic [1:0]                pair;       // 4-op pair of this channel
    logic [4:0]                mod_slot;
    logic [4:0]                car_slot;
    logic                      four_op_en;
    logic                      secondary;
    opl3_mix_pkg::op_sample_t  op_mod;
    opl3_mix_pkg::op_sample_t  op_car;
    opl3_mix_pkg::op_sample_t  op_s0;
    opl3_mix_pkg::op_sample_t  op_s1;
    opl3_mix_pkg::op_sample_t  op_s2;
    opl3_mix_pkg::op_sample_t  op_s3;
    opl3_mix_pkg::chan_value_t two_op_value;
    opl3_mix_pkg::chan_value_t four_op_value;
    opl3_mix_pkg::chan_value_t value;

    function automatic opl3_mix_pkg::chan_value_t widen(input opl3_mix_pkg::op_sample_t op);
        return opl3_mix_pkg::chan_value_t'(op);
    endfunction

    assign bank_sel = (num_banks > 1) && in_item.bank;
    assign bank_ops = ops[bank_sel];
    assign bank_cfg = cfg[bank_sel];
    assign chan_cfg = bank_cfg.chan[in_item.chan];

    // operator slots of the sequenced channel
    always_comb begin
        grp      = 2'(in_item.chan / 4'd3);
        mod_slot = 5'(in_item.chan) + 5'(3 * grp);
        car_slot = mod_slot + 5'd3;

        if (in_item.chan < 4'd3) begin
            pair = in_item.chan[1:0];
        end else if (in_item.chan < 4'd6) begin
            pair = 2'(in_item.chan - 4'd3);
        end else begin
            pair = 2'd0;
        end

        four_op_en = (in_item.chan < 4'd3) && bank_cfg.four_op_sel[pair];
        secondary  = (in_item.chan >= 4'd3) && (in_item.chan < 4'd6)
                     && bank_cfg.four_op_sel[pair];

        op_mod = bank_ops[mod_slot];
        op_car = bank_ops[car_slot];
        op_s0  = bank_ops[pair];
        op_s1  = bank_ops[pair + 3];
        op_s2  = bank_ops[pair + 6];
        op_s3  = bank_ops[pair + 9];
    end

    // 2-op: carrier alone or modulator plus carrier
    assign two_op_value = chan_cfg.cnt ? widen(op_mod) + widen(op_car) : widen(op_car);

    // 4-op algorithms, keyed by cnt of c then cnt of c+3
    always_comb begin
        case ({bank_cfg.chan[pair].cnt, bank_cfg.chan[pair + 3].cnt})
            2'b00:   four_op_value = widen(op_s3);
            2'b01:   four_op_value = widen(op_s1) + widen(op_s3);
            2'b10:   four_op_value = widen(op_s0) + widen(op_s3);
            default: four_op_value = widen(op_s0) + widen(op_s2) + widen(op_s3);
        endcase
    end

    always_comb begin
        if (secondary) begin
            value = '0;                  // partner channel is silent
        end else if (four_op_en) begin
            value = four_op_value;
        end else begin
            value = two_op_value;
        end
    end

    always_ff @(posedge clk) begin
        out_item.pan   <= chan_cfg.pan;
        out_item.value <= value;
        if (reset) begin
            out_item.valid <= 1'b0;
            out_item.last  <= 1'b0;
        end else begin
            out_item.valid <= in_item.valid;
            out_item.last  <= in_item.valid && in_item.last;
        end
    end

endmodule

// File: hdl/opl3_channel_mix.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Channel output mixer: sequencer, connection mixer, accumulator.
// sample_valid rises N+3 edges after the accepted strobe,
// N = 18 in OPL3 mode with two banks, otherwise 9.
// With num_banks = 1, is_new has no effect.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module opl3_channel_mix #(
    parameter int num_banks = 2
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       sample_clk_en,
    input  logic                       is_new,
    input  opl3_mix_pkg::bank_ops_t    ops [num_banks],
    input  opl3_mix_pkg::bank_cfg_t    cfg [num_banks],
    output opl3_mix_pkg::quad_sample_t samples,
    output logic                       sample_valid
);

    opl3_mix_pkg::chan_item_t seq_item;
    opl3_mix_pkg::mix_item_t  mix_item;

    channel_sequencer #(
        .num_banks (num_banks)
    ) u_sequencer (
        .clk           (clk),
        .reset         (reset),
        .sample_clk_en (sample_clk_en),
        .is_new        (is_new),
        .item          (seq_item)
    );

    connection_mixer #(
        .num_banks (num_banks)
    ) u_mixer (
        .clk      (clk),
        .reset    (reset),
        .in_item  (seq_item),
        .ops      (ops),
        .cfg      (cfg),
        .out_item (mix_item)
    );

    output_accumulator u_accumulator (
        .clk          (clk),
        .reset        (reset),
        .in_item      (mix_item),
        .samples      (samples),
        .sample_valid (sample_valid)
    );

endmodule

// File: hdl/opl3_mix_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths and types shared by the channel output mixer.
// Operator outputs are 13-bit signed and held for a whole frame.
// pan bit 0 routes to output a, bit 1 to b, bit 2 to c, bit 3 to d.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package opl3_mix_pkg;

    localparam int op_out_width   = 13;
    localparam int sample_width   = 16;
    localparam int acc_width      = 20;   // 18 channels of three-operator sums
    localparam int ops_per_bank   = 18;
    localparam int chans_per_bank = 9;
    localparam int chan_width     = op_out_width + 2;  // room for three operators

    typedef logic signed [op_out_width-1:0] op_sample_t;
    typedef logic signed [chan_width-1:0]   chan_value_t;
    typedef logic signed [acc_width-1:0]    acc_t;
    typedef logic signed [sample_width-1:0] sample_t;

    // operator outputs of one bank, slot 0 in the low bits
    typedef op_sample_t [ops_per_bank-1:0] bank_ops_t;

    localparam sample_t sample_max = sample_t'(2**(sample_width-1) - 1);
    localparam sample_t sample_min = sample_t'(-(2**(sample_width-1)));

    typedef struct packed {
        logic       cnt;    // connection bit
        logic [3:0] pan;    // routes to d c b a
    } chan_cfg_t;

    typedef struct packed {
        chan_cfg_t [chans_per_bank-1:0] chan;
        logic [2:0]                     four_op_sel;  // pairs 0/3, 1/4, 2/5
    } bank_cfg_t;

    // one channel slot issued by the sequencer
    typedef struct packed {
        logic       valid;
        logic       last;
        logic       bank;
        logic [3:0] chan;
    } chan_item_t;

    // one mixed channel value on its way to the accumulators
    typedef struct packed {
        logic        valid;
        logic        last;
        logic [3:0]  pan;
        chan_value_t value;
    } mix_item_t;

    typedef struct packed {
        sample_t a;
        sample_t b;
        sample_t c;
        sample_t d;
    } quad_sample_t;

    // saturate a frame sum to the signed sample range
    function automatic sample_t clamp_sample(input acc_t v);
        if (v > acc_t'(sample_max)) begin
            return sample_max;
        end
        if (v < acc_t'(sample_min)) begin
            return sample_min;
        end
        return sample_t'(v);
    endfunction

endpackage

// File: hdl/output_accumulator.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sums routed channel values into four frame accumulators.
// First item of a frame loads, later items add.
// Clamped samples and sample_valid follow one edge after last.
// Samples hold until the next frame completes.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module output_accumulator (
    input  logic                       clk,
    input  logic                       reset,
    input  opl3_mix_pkg::mix_item_t    in_item,
    output opl3_mix_pkg::quad_sample_t samples,
    output logic                       sample_valid
);

    opl3_mix_pkg::acc_t acc [4];     // a, b, c, d
    opl3_mix_pkg::acc_t value_ext;
    logic               frame_open;  // an item of this frame was absorbed
    logic               clamp_pending;

    assign value_ext = opl3_mix_pkg::acc_t'(in_item.value);

    always_ff @(posedge clk) begin
        if (in_item.valid) begin
            for (int i = 0; i < 4; i++) begin
                if (!frame_open) begin
                    acc[i] <= in_item.pan[i] ? value_ext : '0;  // frame start
                end else if (in_item.pan[i]) begin
                    acc[i] <= acc[i] + value_ext;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            frame_open    <= 1'b0;
            clamp_pending <= 1'b0;
        end else begin
            clamp_pending <= in_item.valid && in_item.last;
            if (in_item.valid) begin
                frame_open <= !in_item.last;
            end
        end
    end

    // saturate the finished sums
    always_ff @(posedge clk) begin
        if (reset) begin
            samples      <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= clamp_pending;
            if (clamp_pending) begin
                samples.a <= opl3_mix_pkg::clamp_sample(acc[0]);
                samples.b <= opl3_mix_pkg::clamp_sample(acc[1]);
                samples.c <= opl3_mix_pkg::clamp_sample(acc[2]);
                samples.d <= opl3_mix_pkg::clamp_sample(acc[3]);
            end
        end
    end

endmodule

// File: sim/opl3_channel_mix_asserts.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pipeline handshake checks, bound into opl3_channel_mix.
// error_count is read by the testbench to stop the run.
// Assumes sample_clk_en is a one-cycle strobe.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module opl3_channel_mix_asserts (
    input logic                     clk,
    input logic                     reset,
    input logic                     sample_clk_en,
    input logic                     sample_valid,
    input opl3_mix_pkg::chan_item_t seq_item
);

    int unsigned error_count = 0;

    valid_is_pulse: assert property (@(posedge clk) disable iff (reset)
        sample_valid |=> !sample_valid)
    else begin
        error_count++;
        $error("sample_valid stayed high for more than one cycle");
    end

    valid_low_in_reset: assert property (@(posedge clk) $past(reset) |-> !sample_valid)
    else begin
        error_count++;
        $error("sample_valid high while reset was applied");
    end

    // a new frame of items needs a strobe two edges earlier
    item_needs_strobe: assert property (@(posedge clk) disable iff (reset)
        $rose(seq_item.valid) |-> $past(sample_clk_en, 2))
    else begin
        error_count++;
        $error("sequencer issued items without a new strobe");
    end

    idle_after_last: assert property (@(posedge clk) disable iff (reset)
        (seq_item.valid && seq_item.last) |=> !seq_item.valid)
    else begin
        error_count++;
        $error("sequencer issued an item right after last");
    end

endmodule

// File: include/mix_ref.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model of one frame: four clamped output samples.
// Walks channels in a plain loop, no pipeline timing.
// ops and cfg need num_banks entries.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MIX_REF_SVH
`define MIX_REF_SVH

// one operator slot, sign extended to a channel value
function automatic opl3_mix_pkg::chan_value_t mix_ref_op(input opl3_mix_pkg::bank_ops_t b,
                                                         input int slot);
    opl3_mix_pkg::op_sample_t op;
    op = b[slot];
    return opl3_mix_pkg::chan_value_t'(op);
endfunction

// signed 16-bit saturation of a frame sum
function automatic opl3_mix_pkg::sample_t saturate_sum(input opl3_mix_pkg::acc_t sum);
    if (sum > 32767) begin
        return 16'h7fff;
    end
    if (sum < -32768) begin
        return 16'h8000;
    end
    return sum[15:0];
endfunction

function automatic opl3_mix_pkg::quad_sample_t mix_ref(input opl3_mix_pkg::bank_ops_t ops [],
                                                       input opl3_mix_pkg::bank_cfg_t cfg [],
                                                       input logic is_new,
                                                       input int num_banks);
    opl3_mix_pkg::acc_t        acc [4];
    opl3_mix_pkg::chan_value_t v;
    opl3_mix_pkg::quad_sample_t res;
    int                        banks_used;
    int                        mod;

    banks_used = (is_new && num_banks > 1) ? 2 : 1;
    foreach (acc[i]) acc[i] = '0;
    for (int b = 0; b < banks_used; b++) begin
        for (int c = 0; c < opl3_mix_pkg::chans_per_bank; c++) begin
            mod = c + 3 * (c / 3);
            if (c < 3 && cfg[b].four_op_sel[c]) begin
                case ({cfg[b].chan[c].cnt, cfg[b].chan[c + 3].cnt})
                    2'b00:   v = mix_ref_op(ops[b], c + 9);
                    2'b01:   v = mix_ref_op(ops[b], c + 3) + mix_ref_op(ops[b], c + 9);
                    2'b10:   v = mix_ref_op(ops[b], c) + mix_ref_op(ops[b], c + 9);
                    default: v = mix_ref_op(ops[b], c) + mix_ref_op(ops[b], c + 6)
                                 + mix_ref_op(ops[b], c + 9);
                endcase
            end else if (c >= 3 && c < 6 && cfg[b].four_op_sel[c - 3]) begin
                v = '0;
            end else if (cfg[b].chan[c].cnt) begin
                v = mix_ref_op(ops[b], mod) + mix_ref_op(ops[b], mod + 3);
            end else begin
                v = mix_ref_op(ops[b], mod + 3);
            end
            for (int i = 0; i < 4; i++) begin
                if (cfg[b].chan[c].pan[i]) acc[i] += opl3_mix_pkg::acc_t'(v);
            end
        end
    end
    res.a = saturate_sum(acc[0]);
    res.b = saturate_sum(acc[1]);
    res.c = saturate_sum(acc[2]);
    res.d = saturate_sum(acc[3]);
    return res;
endfunction

`endif

// File: sim/tb_opl3_channel_mix.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the channel output mixer, two banks.
// ops and cfg change only between frames, on the falling edge.
// Expected samples come from mix_ref in include/mix_ref.svh.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_opl3_channel_mix;

    localparam int num_banks    = 2;
    localparam int num_frames   = 22;
    localparam int reset_cycles = 8;
    localparam int clk_period   = 8;
    localparam int watchdog_ns  = (num_frames * (18 + 3) + reset_cycles) * clk_period * 2;

    logic                       clk;
    logic                       reset;
    logic                       sample_clk_en;
    logic                       is_new;
    opl3_mix_pkg::bank_ops_t    ops [num_banks];
    opl3_mix_pkg::bank_cfg_t    cfg [num_banks];
    opl3_mix_pkg::quad_sample_t samples;
    logic                       sample_valid;

    opl3_mix_pkg::quad_sample_t exp_samples;
    int                         exp_latency;
    int                         edge_count;
    int                         strobe_edge;   // edge that samples the strobe
    logic                       pending;       // a frame awaits its sample_valid
    int                         frames_started;
    int                         frames_done;

    `include "mix_ref.svh"

    opl3_channel_mix #(
        .num_banks (num_banks)
    ) opl3_channel_mix_inst (
        .clk           (clk),
        .reset         (reset),
        .sample_clk_en (sample_clk_en),
        .is_new        (is_new),
        .ops           (ops),
        .cfg           (cfg),
        .samples       (samples),
        .sample_valid  (sample_valid)
    );

    bind opl3_channel_mix opl3_channel_mix_asserts asserts_inst (
        .clk           (clk),
        .reset         (reset),
        .sample_clk_en (sample_clk_en),
        .sample_valid  (sample_valid),
        .seq_item      (seq_item)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) edge_count <= edge_count + 1;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_samples(input string name, input opl3_mix_pkg::quad_sample_t got,
                                 input opl3_mix_pkg::quad_sample_t exp);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_cycles(input string name, input int got, input int exp);
        if (got != exp) begin
            stop_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    function automatic opl3_mix_pkg::bank_ops_t random_ops();
        opl3_mix_pkg::bank_ops_t b;
        for (int i = 0; i < opl3_mix_pkg::ops_per_bank; i++) begin
            b[i] = opl3_mix_pkg::op_sample_t'($urandom);
        end
        return b;
    endfunction

    function automatic opl3_mix_pkg::bank_cfg_t random_cfg();
        logic [47:0] bits;
        bits = 48'({$urandom, $urandom});
        return bits;
    endfunction

    // compare process, samples at the falling edge where outputs are settled
    always @(negedge clk) begin
        if (opl3_channel_mix_inst.asserts_inst.error_count != 0) begin
            stop_run("a bound assertion on the mixer pipeline failed");
        end
        if (!reset && sample_valid) begin
            if (!pending) begin
                stop_run("sample_valid pulsed with no frame outstanding");
            end
            check_cycles("sample_valid latency", edge_count - strobe_edge, exp_latency);
            check_samples("samples", samples, exp_samples);
            pending     <= 1'b0;
            frames_done <= frames_done + 1;
        end
    end

    // one frame with the current ops and cfg, called at a falling edge
    task automatic run_frame(input logic new_mode, input logic extra_strobe);
        opl3_mix_pkg::bank_ops_t ref_ops [];
        opl3_mix_pkg::bank_cfg_t ref_cfg [];
        ref_ops = new[num_banks];
        ref_cfg = new[num_banks];
        for (int b = 0; b < num_banks; b++) begin
            ref_ops[b] = ops[b];
            ref_cfg[b] = cfg[b];
        end
        is_new      = new_mode;
        exp_samples = mix_ref(ref_ops, ref_cfg, new_mode, num_banks);
        exp_latency = ((new_mode && num_banks > 1) ? 18 : 9) + 3;
        strobe_edge = edge_count + 1;
        pending     = 1'b1;
        frames_started++;
        sample_clk_en = 1'b1;
        @(negedge clk);
        sample_clk_en = 1'b0;
        if (extra_strobe) begin
            repeat (5) @(negedge clk);
            sample_clk_en = 1'b1;        // lands mid-frame
            @(negedge clk);
            sample_clk_en = 1'b0;
        end
        while (frames_done != frames_started) @(negedge clk);
        repeat (extra_strobe ? 25 : 2) @(negedge clk);  // room for a stray pulse
    endtask

    initial begin
        opl3_mix_pkg::quad_sample_t routed;
        opl3_mix_pkg::op_sample_t   carrier;
        logic [1:0]                 combo;
        void'($urandom(18760));
        reset          = 1'b1;
        sample_clk_en  = 1'b0;
        is_new         = 1'b0;
        pending        = 1'b0;
        edge_count     = 0;
        strobe_edge    = 0;
        exp_latency    = 0;
        exp_samples    = '0;
        frames_started = 0;
        frames_done    = 0;
        for (int b = 0; b < num_banks; b++) begin
            ops[b] = '0;
            cfg[b] = '0;
        end
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (2) @(negedge clk);

        // OPL2, 2-op, then bank 1 changed alone
        for (int k = 0; k < 4; k++) begin
            for (int b = 0; b < num_banks; b++) begin
                ops[b] = random_ops();
                cfg[b] = random_cfg();
                cfg[b].four_op_sel = 3'b000;
            end
            run_frame(1'b0, 1'b0);
            ops[1] = random_ops();
            cfg[1] = random_cfg();
            run_frame(1'b0, 1'b0);
        end

        // OPL3, every pair in 4-op mode, each cnt combination per pair
        for (int k = 0; k < 4; k++) begin
            for (int b = 0; b < num_banks; b++) begin
                ops[b] = random_ops();
                cfg[b] = random_cfg();
                cfg[b].four_op_sel = 3'b111;
                for (int p = 0; p < 3; p++) begin
                    combo = 2'(k + p);
                    cfg[b].chan[p].cnt     = combo[1];
                    cfg[b].chan[p + 3].cnt = combo[0];
                    cfg[b].chan[p + 3].pan = 4'hf;  // secondary routed everywhere
                end
            end
            run_frame(1'b1, 1'b0);
        end
        for (int k = 0; k < 2; k++) begin
            for (int b = 0; b < num_banks; b++) begin
                ops[b] = random_ops();
                cfg[b] = random_cfg();
            end
            run_frame(1'b1, 1'b0);
        end

        // one channel routed to one output at a time
        for (int out = 0; out < 4; out++) begin
            ops[0]  = random_ops();
            cfg[0]  = '0;
            carrier = opl3_mix_pkg::op_sample_t'($urandom | 1);
            ops[0][3] = carrier;         // carrier slot of channel 0
            cfg[0].chan[0].pan = 4'(1 << out);
            routed = '0;
            case (out)
                0: routed.a = opl3_mix_pkg::sample_t'(carrier);
                1: routed.b = opl3_mix_pkg::sample_t'(carrier);
                2: routed.c = opl3_mix_pkg::sample_t'(carrier);
                default: routed.d = opl3_mix_pkg::sample_t'(carrier);
            endcase
            run_frame(1'b0, 1'b0);
            check_samples("routed samples", samples, routed);
        end

        // saturation at both ends
        for (int k = 0; k < 2; k++) begin
            for (int b = 0; b < num_banks; b++) begin
                for (int i = 0; i < opl3_mix_pkg::ops_per_bank; i++) begin
                    ops[b][i] = (k == 0) ? 13'h0fff : 13'h1000;
                end
                cfg[b] = '0;
                for (int c = 0; c < opl3_mix_pkg::chans_per_bank; c++) begin
                    cfg[b].chan[c].cnt = 1'b1;
                    cfg[b].chan[c].pan = 4'hf;
                end
            end
            run_frame(1'b1, 1'b0);
            check_samples("saturated samples", samples,
                          (k == 0) ? {4{16'h7fff}} : {4{16'h8000}});
        end

        // a second strobe inside a running frame in both modes
        for (int k = 0; k < 2; k++) begin
            for (int b = 0; b < num_banks; b++) begin
                ops[b] = random_ops();
                cfg[b] = random_cfg();
            end
            run_frame(k == 1, 1'b1);
        end

        if (opl3_channel_mix_inst.asserts_inst.error_count == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            stop_run("a bound assertion on the mixer pipeline failed");
        end
    end

    initial begin
        #(watchdog_ns);
        stop_run("watchdog expired, the run did not finish in time");
    end

endmodule
